// File: src/exec_pkg.sv
/*
  Shared types and constants for the RV32I execute stage.
  Holds the data widths, the ALU, branch, load and forwarding encodings,
  and the ID/EX, compute-result and EX/MEM structs. Modules refer to
  everything here through exec_pkg:: scoped names.
*/
package exec_pkg;

  // Plain data widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [1:0]  byte_off_t;

  // Operand select codes
  typedef logic        a_sel_t;
  typedef logic [1:0]  b_sel_t;

  localparam a_sel_t A_SEL_RS1 = 1'b0;
  localparam a_sel_t A_SEL_DEC = 1'b1;
  localparam b_sel_t B_SEL_RS1 = 2'd0;
  localparam b_sel_t B_SEL_RS2 = 2'd1;
  localparam b_sel_t B_SEL_DEC = 2'd2;

  localparam int SHAMT_W = 5;

  localparam byte_en_t BYTE_EN_NONE = 4'b0000;
  localparam byte_en_t BYTE_EN_WORD = 4'b1111;

  typedef enum logic [3:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_SRA  = 4'd2,
    ALU_ADD  = 4'd3,
    ALU_SUB  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // funct3 of the conditional branches
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_t;

  // funct3 shared by loads and stores
  typedef enum logic [2:0] {
    LD_LB  = 3'b000,
    LD_LH  = 3'b001,
    LD_LW  = 3'b010,
    LD_LBU = 3'b100,
    LD_LHU = 3'b101
  } load_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_M    = 2'd1,
    FWD_W    = 2'd2
  } fwd_sel_t;

  // Instruction entering EX
  typedef struct packed {
    word_t    pc;
    word_t    pc4;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    op_a;
    word_t    op_b;
    a_sel_t   a_sel;
    b_sel_t   b_sel;
    alu_op_t  aluop;
    reg_idx_t reg_rs1;
    reg_idx_t reg_rs2;
    reg_idx_t reg_rd;
    logic     wen;
    logic     dren;
    logic     dwen;
    load_t    load_type;
    logic     branch_instr;
    branch_t  branch_type;
    word_t    br_imm;
    logic     jump_instr;
    logic     j_sel;
    word_t    j_offset;
    logic     prediction;
    logic     halt_instr;
  } id_ex_t;

  // Combinational results of the compute stage
  typedef struct packed {
    word_t    alu_out;
    word_t    store_wdata;
    byte_en_t byte_en;
    logic     branch_taken;
    word_t    br_resolved_addr;
    word_t    jump_addr;
  } exec_result_t;

  // EX/MEM register contents
  typedef struct packed {
    word_t    result;
    word_t    memory_addr;
    word_t    store_wdata;
    byte_en_t byte_en;
    load_t    load_type;
    reg_idx_t reg_rd;
    logic     wen;
    logic     dren;
    logic     dwen;
    logic     branch_instr;
    logic     branch_taken;
    logic     prediction;
    word_t    br_resolved_addr;
    logic     jump_instr;
    word_t    jump_addr;
    word_t    pc;
    word_t    pc4;
    logic     halt_instr;
    logic     token;
  } ex_mem_t;

endpackage

// File: src/operand_forward.sv
/*
  Operand selection for the instruction in EX.
  Replaces rs1/rs2 with the memory or writeback stage value when the
  forwarding unit asks for it, then builds the two ALU operands.
*/
`timescale 1ns/1ps

module operand_forward (
  input  exec_pkg::id_ex_t   id_ex,
  input  exec_pkg::fwd_sel_t fwd_rs1,
  input  exec_pkg::fwd_sel_t fwd_rs2,
  input  exec_pkg::word_t    rd_data_mem,
  input  exec_pkg::word_t    rd_data_wb,
  output exec_pkg::word_t    rs1_val,
  output exec_pkg::word_t    rs2_val,
  output exec_pkg::word_t    alu_a,
  output exec_pkg::word_t    alu_b
);

  function automatic exec_pkg::word_t fwd_pick(
    input exec_pkg::fwd_sel_t sel,
    input exec_pkg::word_t    reg_val,
    input exec_pkg::word_t    mem_val,
    input exec_pkg::word_t    wb_val
  );
    case (sel)
      exec_pkg::FWD_M: fwd_pick = mem_val;
      exec_pkg::FWD_W: fwd_pick = wb_val;
      default:         fwd_pick = reg_val;
    endcase
  endfunction

  assign rs1_val = fwd_pick(fwd_rs1, id_ex.rs1_data, rd_data_mem, rd_data_wb);
  assign rs2_val = fwd_pick(fwd_rs2, id_ex.rs2_data, rd_data_mem, rd_data_wb);

  assign alu_a = (id_ex.a_sel == exec_pkg::A_SEL_RS1) ? rs1_val : id_ex.op_a;

  // Operand B may also take rs1, as the decoder requests
  always_comb begin
    case (id_ex.b_sel)
      exec_pkg::B_SEL_RS1: alu_b = rs1_val;
      exec_pkg::B_SEL_RS2: alu_b = rs2_val;
      default:             alu_b = id_ex.op_b;
    endcase
  end

endmodule

// File: src/int_alu.sv
/*
  Integer ALU for the RV32I register and immediate operations.
  Purely combinational; the shift amount is the low bits of b and
  the compares return 1 or 0.
*/
`timescale 1ns/1ps

module int_alu (
  input  exec_pkg::word_t   a,
  input  exec_pkg::word_t   b,
  input  exec_pkg::alu_op_t aluop,
  output exec_pkg::word_t   alu_out
);

  logic [exec_pkg::SHAMT_W-1:0] shamt;
  logic                         lt_signed;
  logic                         lt_unsigned;

  assign shamt       = b[exec_pkg::SHAMT_W-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (aluop)
      exec_pkg::ALU_ADD:  alu_out = a + b;
      exec_pkg::ALU_SUB:  alu_out = a - b;
      exec_pkg::ALU_AND:  alu_out = a & b;
      exec_pkg::ALU_OR:   alu_out = a | b;
      exec_pkg::ALU_XOR:  alu_out = a ^ b;
      exec_pkg::ALU_SLL:  alu_out = a << shamt;
      exec_pkg::ALU_SRL:  alu_out = a >> shamt;
      // Arithmetic shift keeps the sign bit
      exec_pkg::ALU_SRA:  alu_out = exec_pkg::word_t'($signed(a) >>> shamt);
      exec_pkg::ALU_SLT:  alu_out = {31'd0, lt_signed};
      exec_pkg::ALU_SLTU: alu_out = {31'd0, lt_unsigned};
      default:            alu_out = '0;
    endcase
  end

endmodule

// File: src/branch_resolve.sv
/*
  Branch and jump resolution in EX.
  Compares the forwarded operands by branch type, forms the branch
  target and the next address, and computes the JAL/JALR target.
*/
`timescale 1ns/1ps

module branch_resolve (
  input  exec_pkg::id_ex_t id_ex,
  input  exec_pkg::word_t  rs1_val,
  input  exec_pkg::word_t  rs2_val,
  output logic             branch_taken,
  output exec_pkg::word_t  br_resolved_addr,
  output exec_pkg::word_t  jump_addr
);

  exec_pkg::word_t branch_target;
  exec_pkg::word_t jump_base;
  exec_pkg::word_t jump_sum;
  logic            cond;

  always_comb begin
    case (id_ex.branch_type)
      exec_pkg::BR_BEQ:  cond = rs1_val == rs2_val;
      exec_pkg::BR_BNE:  cond = rs1_val != rs2_val;
      exec_pkg::BR_BLT:  cond = $signed(rs1_val) < $signed(rs2_val);
      exec_pkg::BR_BGE:  cond = $signed(rs1_val) >= $signed(rs2_val);
      exec_pkg::BR_BLTU: cond = rs1_val < rs2_val;
      exec_pkg::BR_BGEU: cond = rs1_val >= rs2_val;
      default:           cond = 1'b0;
    endcase
  end

  assign branch_taken     = id_ex.branch_instr & cond;
  assign branch_target    = id_ex.pc + id_ex.br_imm;
  assign br_resolved_addr = branch_taken ? branch_target : id_ex.pc4;

  // JAL is pc relative, JALR uses rs1 and drops bit 0
  assign jump_base = id_ex.j_sel ? id_ex.pc : rs1_val;
  assign jump_sum  = jump_base + id_ex.j_offset;
  assign jump_addr = id_ex.j_sel ? jump_sum : {jump_sum[31:1], 1'b0};

endmodule

// File: src/mem_byte_enable.sv
/*
  Byte-lane decoder for data accesses, shared by loads and stores.
  Misaligned halfwords and unknown widths enable no lanes.
*/
`timescale 1ns/1ps

module mem_byte_enable (
  input  exec_pkg::load_t     load_type,
  input  exec_pkg::byte_off_t offset,
  output exec_pkg::byte_en_t  byte_en
);

  always_comb begin
    case (load_type)
      exec_pkg::LD_LB,
      exec_pkg::LD_LBU: byte_en = exec_pkg::byte_en_t'(1) << offset;
      exec_pkg::LD_LH,
      exec_pkg::LD_LHU: begin
        case (offset)
          2'b00:   byte_en = 4'b0011;
          2'b10:   byte_en = 4'b1100;
          default: byte_en = exec_pkg::BYTE_EN_NONE;
        endcase
      end
      exec_pkg::LD_LW:  byte_en = exec_pkg::BYTE_EN_WORD;
      default:          byte_en = exec_pkg::BYTE_EN_NONE;
    endcase
  end

endmodule

// File: src/ex_mem_latch.sv
/*
  EX/MEM pipeline register.
  In priority order: halt or a flush clears it, a granted data access
  drops only the memory request, pc_en loads it, otherwise it holds.
  Every load marks the entry valid through token.
*/
`timescale 1ns/1ps

module ex_mem_latch (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   halt,
  input  logic                   pc_en,
  input  logic                   ex_mem_flush,
  input  logic                   dmem_access,
  input  logic                   dmem_busy,
  input  exec_pkg::id_ex_t       id_ex,
  input  exec_pkg::exec_result_t res,
  output exec_pkg::ex_mem_t      ex_mem
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_mem <= '0;
    end else if (halt || (ex_mem_flush && pc_en)) begin
      ex_mem <= '0;
    end else if (dmem_access && !dmem_busy) begin
      // Data side got the bus, so do not issue the request again
      ex_mem.dren <= 1'b0;
      ex_mem.dwen <= 1'b0;
    end else if (pc_en) begin
      ex_mem.result           <= res.alu_out;
      ex_mem.memory_addr      <= res.alu_out;
      ex_mem.store_wdata      <= res.store_wdata;
      ex_mem.byte_en          <= res.byte_en;
      ex_mem.load_type        <= id_ex.load_type;
      ex_mem.reg_rd           <= id_ex.reg_rd;
      ex_mem.wen              <= id_ex.wen;
      ex_mem.dren             <= id_ex.dren;
      ex_mem.dwen             <= id_ex.dwen;
      // Branch and jump outcome for the fetch redirect
      ex_mem.branch_instr     <= id_ex.branch_instr;
      ex_mem.branch_taken     <= res.branch_taken;
      ex_mem.prediction       <= id_ex.prediction;
      ex_mem.br_resolved_addr <= res.br_resolved_addr;
      ex_mem.jump_instr       <= id_ex.jump_instr;
      ex_mem.jump_addr        <= res.jump_addr;
      ex_mem.pc               <= id_ex.pc;
      ex_mem.pc4              <= id_ex.pc4;
      ex_mem.halt_instr       <= id_ex.halt_instr;
      ex_mem.token            <= 1'b1;
    end
  end

endmodule

// File: src/execute_stage.sv
/*
  Execute stage of the five-stage RV32I pipeline.
  Operand forwarding, ALU, branch/jump resolution and byte enables are
  combinational; the EX/MEM register adds the single cycle of latency.
  Hazard controls come straight from the hazard unit.
*/
`timescale 1ns/1ps

module execute_stage (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               halt,
  input  exec_pkg::id_ex_t   id_ex,
  input  exec_pkg::fwd_sel_t fwd_rs1,
  input  exec_pkg::fwd_sel_t fwd_rs2,
  input  exec_pkg::word_t    rd_data_mem,
  input  exec_pkg::word_t    rd_data_wb,
  input  logic               pc_en,
  input  logic               ex_mem_flush,
  input  logic               dmem_access,
  input  logic               dmem_busy,
  output exec_pkg::ex_mem_t  ex_mem
);

  exec_pkg::word_t        rs1_val;
  exec_pkg::word_t        rs2_val;
  exec_pkg::word_t        alu_a;
  exec_pkg::word_t        alu_b;
  exec_pkg::word_t        alu_out;
  logic                   branch_taken;
  exec_pkg::word_t        br_resolved_addr;
  exec_pkg::word_t        jump_addr;
  exec_pkg::byte_en_t     byte_en;
  exec_pkg::exec_result_t res;

  // Operand stage
  operand_forward operand_forward_inst (
    .id_ex       (id_ex),
    .fwd_rs1     (fwd_rs1),
    .fwd_rs2     (fwd_rs2),
    .rd_data_mem (rd_data_mem),
    .rd_data_wb  (rd_data_wb),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .alu_a       (alu_a),
    .alu_b       (alu_b)
  );

  // Compute stage
  int_alu int_alu_inst (
    .a       (alu_a),
    .b       (alu_b),
    .aluop   (id_ex.aluop),
    .alu_out (alu_out)
  );

  branch_resolve branch_resolve_inst (
    .id_ex            (id_ex),
    .rs1_val          (rs1_val),
    .rs2_val          (rs2_val),
    .branch_taken     (branch_taken),
    .br_resolved_addr (br_resolved_addr),
    .jump_addr        (jump_addr)
  );

  mem_byte_enable mem_byte_enable_inst (
    .load_type (id_ex.load_type),
    .offset    (alu_out[1:0]),
    .byte_en   (byte_en)
  );

  assign res = '{
    alu_out:          alu_out,
    store_wdata:      rs2_val,
    byte_en:          byte_en,
    branch_taken:     branch_taken,
    br_resolved_addr: br_resolved_addr,
    jump_addr:        jump_addr
  };

  // Register stage
  ex_mem_latch ex_mem_latch_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .halt         (halt),
    .pc_en        (pc_en),
    .ex_mem_flush (ex_mem_flush),
    .dmem_access  (dmem_access),
    .dmem_busy    (dmem_busy),
    .id_ex        (id_ex),
    .res          (res),
    .ex_mem       (ex_mem)
  );

endmodule

// File: sim/execute_tb.sv
/*
  Testbench for the RV32I execute stage.
  Drives random and directed ID/EX instructions, forwarding selects and
  hazard controls, and checks the EX/MEM register one clock later against
  a reference model of the stage's rules.
*/
`timescale 1ns/1ps

module execute_tb;

  localparam time CLK_PERIOD   = 40ns;
  localparam time DRIVE_DELAY  = 2ns;
  localparam int  LOAD_TIMEOUT = 8;
  localparam int  ENTRY_W      = $bits(exec_pkg::ex_mem_t);

  logic               CLK;
  logic               nRST;
  logic               halt;
  exec_pkg::id_ex_t   id_ex;
  exec_pkg::fwd_sel_t fwd_rs1;
  exec_pkg::fwd_sel_t fwd_rs2;
  exec_pkg::word_t    rd_data_mem;
  exec_pkg::word_t    rd_data_wb;
  logic               pc_en;
  logic               ex_mem_flush;
  logic               dmem_access;
  logic               dmem_busy;
  exec_pkg::ex_mem_t  ex_mem;

  integer          seed;
  exec_pkg::word_t next_pc;

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  execute_stage execute_stage_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .halt         (halt),
    .id_ex        (id_ex),
    .fwd_rs1      (fwd_rs1),
    .fwd_rs2      (fwd_rs2),
    .rd_data_mem  (rd_data_mem),
    .rd_data_wb   (rd_data_wb),
    .pc_en        (pc_en),
    .ex_mem_flush (ex_mem_flush),
    .dmem_access  (dmem_access),
    .dmem_busy    (dmem_busy),
    .ex_mem       (ex_mem)
  );

  task automatic report_mismatch(
    input string              name,
    input logic [ENTRY_W-1:0] expected,
    input logic [ENTRY_W-1:0] actual
  );
    $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s mismatched", name);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "wait expired");
  endtask

  // An entry without token must be all zeros
  assert property (@(posedge CLK) disable iff (!nRST) !ex_mem.token |-> ex_mem == '0)
    else report_mismatch("empty entry", '0, $sampled(ex_mem));

  task automatic check_word(
    input string           name,
    input exec_pkg::word_t expected,
    input exec_pkg::word_t actual
  );
    assert (actual === expected)
      else report_mismatch(name, ENTRY_W'(expected), ENTRY_W'(actual));
  endtask

  task automatic check_entry(input string name, input exec_pkg::ex_mem_t expected);
    check_word({name, " result"}, expected.result, ex_mem.result);
    check_word({name, " store_wdata"}, expected.store_wdata, ex_mem.store_wdata);
    check_word({name, " byte_en"}, 32'(expected.byte_en), 32'(ex_mem.byte_en));
    check_word({name, " branch_taken"}, 32'(expected.branch_taken), 32'(ex_mem.branch_taken));
    check_word({name, " br_resolved_addr"}, expected.br_resolved_addr,
               ex_mem.br_resolved_addr);
    check_word({name, " jump_addr"}, expected.jump_addr, ex_mem.jump_addr);
    assert (ex_mem === expected)
      else report_mismatch({name, " entry"}, expected, ex_mem);
  endtask

  task automatic next_edge();
    @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  function automatic exec_pkg::word_t pick_operand(
    input exec_pkg::fwd_sel_t sel,
    input exec_pkg::word_t    reg_val,
    input exec_pkg::word_t    mem_val,
    input exec_pkg::word_t    wb_val
  );
    if (sel == exec_pkg::FWD_M) return mem_val;
    if (sel == exec_pkg::FWD_W) return wb_val;
    return reg_val;
  endfunction

  function automatic exec_pkg::word_t model_alu(
    input exec_pkg::alu_op_t op,
    input exec_pkg::word_t   a,
    input exec_pkg::word_t   b
  );
    logic [4:0]      sh;
    exec_pkg::word_t fill;
    sh = b[4:0];
    // Sign bits shifted in from the top
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
    case (op)
      exec_pkg::ALU_ADD:  return a + b;
      exec_pkg::ALU_SUB:  return a + ~b + 32'd1;
      exec_pkg::ALU_AND:  return a & b;
      exec_pkg::ALU_OR:   return a | b;
      exec_pkg::ALU_XOR:  return a ^ b;
      exec_pkg::ALU_SLL:  return a << sh;
      exec_pkg::ALU_SRL:  return a >> sh;
      exec_pkg::ALU_SRA:  return (a >> sh) | fill;
      exec_pkg::ALU_SLT:  return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      exec_pkg::ALU_SLTU: return {31'd0, a < b};
      default:            return 32'd0;
    endcase
  endfunction

  function automatic logic branch_cond(
    input exec_pkg::branch_t bt,
    input exec_pkg::word_t   a,
    input exec_pkg::word_t   b
  );
    logic lt_s;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (bt)
      exec_pkg::BR_BEQ:  return a == b;
      exec_pkg::BR_BNE:  return a != b;
      exec_pkg::BR_BLT:  return lt_s;
      exec_pkg::BR_BGE:  return !lt_s;
      exec_pkg::BR_BLTU: return a < b;
      exec_pkg::BR_BGEU: return !(a < b);
      default:           return 1'b0;
    endcase
  endfunction

  function automatic exec_pkg::byte_en_t lane_enables(
    input exec_pkg::load_t     width,
    input exec_pkg::byte_off_t off
  );
    case (width)
      exec_pkg::LD_LB, exec_pkg::LD_LBU: return 4'b0001 << off;
      exec_pkg::LD_LH, exec_pkg::LD_LHU: begin
        if (off == 2'd0) return 4'b0011;
        if (off == 2'd2) return 4'b1100;
        return 4'b0000;
      end
      exec_pkg::LD_LW: return 4'b1111;
      default:         return 4'b0000;
    endcase
  endfunction

  // Reference EX/MEM entry for one instruction loaded with pc_en high
  function automatic exec_pkg::ex_mem_t expected_entry(
    input exec_pkg::id_ex_t   i,
    input exec_pkg::fwd_sel_t f1,
    input exec_pkg::fwd_sel_t f2,
    input exec_pkg::word_t    mem_val,
    input exec_pkg::word_t    wb_val
  );
    exec_pkg::word_t   rs1;
    exec_pkg::word_t   rs2;
    exec_pkg::word_t   a;
    exec_pkg::word_t   b;
    exec_pkg::word_t   jump;
    exec_pkg::ex_mem_t e;
    rs1 = pick_operand(f1, i.rs1_data, mem_val, wb_val);
    rs2 = pick_operand(f2, i.rs2_data, mem_val, wb_val);
    a = (i.a_sel == exec_pkg::A_SEL_DEC) ? i.op_a : rs1;
    if (i.b_sel == exec_pkg::B_SEL_RS1) b = rs1;
    else if (i.b_sel == exec_pkg::B_SEL_RS2) b = rs2;
    else b = i.op_b;
    jump = (i.j_sel ? i.pc : rs1) + i.j_offset;
    if (!i.j_sel) jump[0] = 1'b0;
    e = '0;
    e.result = model_alu(i.aluop, a, b);
    e.memory_addr = e.result;
    e.store_wdata = rs2;
    e.byte_en = lane_enables(i.load_type, e.result[1:0]);
    e.load_type = i.load_type;
    e.reg_rd = i.reg_rd;
    e.wen = i.wen;
    e.dren = i.dren;
    e.dwen = i.dwen;
    e.branch_instr = i.branch_instr;
    e.branch_taken = i.branch_instr && branch_cond(i.branch_type, rs1, rs2);
    e.prediction = i.prediction;
    e.br_resolved_addr = e.branch_taken ? i.pc + i.br_imm : i.pc4;
    e.jump_instr = i.jump_instr;
    e.jump_addr = jump;
    e.pc = i.pc;
    e.pc4 = i.pc4;
    e.halt_instr = i.halt_instr;
    e.token = 1'b1;
    return e;
  endfunction

  function automatic exec_pkg::word_t fresh_pc();
    next_pc += 32'd4;
    return next_pc;
  endfunction

  // Random ADD of rs1 and rs2 with the other fields random
  // Load width and branch type may take unused codes
  function automatic exec_pkg::id_ex_t random_instr(input exec_pkg::word_t pc);
    exec_pkg::id_ex_t i;
    logic [31:0]      r;
    i = '0;
    r = $random(seed);
    i.pc = pc;
    i.pc4 = pc + 32'd4;
    i.rs1_data = $random(seed);
    i.rs2_data = $random(seed);
    i.op_a = $random(seed);
    i.op_b = $random(seed);
    i.a_sel = exec_pkg::A_SEL_RS1;
    i.b_sel = exec_pkg::B_SEL_RS2;
    i.aluop = exec_pkg::ALU_ADD;
    i.reg_rs1 = r[4:0];
    i.reg_rs2 = r[9:5];
    i.reg_rd = r[14:10];
    i.wen = r[15];
    i.dren = r[16];
    i.dwen = r[17];
    i.prediction = r[18];
    i.branch_instr = r[19];
    i.jump_instr = r[20];
    i.j_sel = r[21];
    i.load_type = exec_pkg::load_t'(r[24:22]);
    i.branch_type = exec_pkg::branch_t'(r[27:25]);
    i.br_imm = $random(seed);
    i.j_offset = $random(seed);
    return i;
  endfunction

  task automatic drive_idle();
    halt         = 1'b0;
    id_ex        = '0;
    fwd_rs1      = exec_pkg::FWD_NONE;
    fwd_rs2      = exec_pkg::FWD_NONE;
    rd_data_mem  = '0;
    rd_data_wb   = '0;
    pc_en        = 1'b0;
    ex_mem_flush = 1'b0;
    dmem_access  = 1'b0;
    dmem_busy    = 1'b0;
  endtask

  // Present one instruction with pc_en high and wait for it in EX/MEM
  task automatic issue(
    input string              name,
    input exec_pkg::id_ex_t   instr,
    input exec_pkg::fwd_sel_t f1,
    input exec_pkg::fwd_sel_t f2
  );
    exec_pkg::ex_mem_t expected;
    int                cycles;
    id_ex       = instr;
    fwd_rs1     = f1;
    fwd_rs2     = f2;
    rd_data_mem = $random(seed);
    rd_data_wb  = $random(seed);
    pc_en       = 1'b1;
    expected = expected_entry(instr, f1, f2, rd_data_mem, rd_data_wb);
    cycles = 0;
    while (!(ex_mem.token && ex_mem.pc == instr.pc) && cycles < LOAD_TIMEOUT) begin
      next_edge();
      cycles++;
    end
    if (!(ex_mem.token && ex_mem.pc == instr.pc)) begin
      report_timeout({name, " to reach EX/MEM"});
    end else begin
      check_word({name, " latency"}, 32'd1, exec_pkg::word_t'(cycles));
      check_entry(name, expected);
    end
  endtask

  task automatic run_branch(
    input exec_pkg::branch_t bt,
    input exec_pkg::word_t   a,
    input exec_pkg::word_t   b
  );
    exec_pkg::id_ex_t instr;
    instr = random_instr(fresh_pc());
    instr.branch_instr = 1'b1;
    instr.branch_type = bt;
    instr.rs1_data = a;
    instr.rs2_data = b;
    issue($sformatf("branch %s", bt.name()), instr, exec_pkg::FWD_NONE, exec_pkg::FWD_NONE);
  endtask

  initial begin
    exec_pkg::ex_mem_t zero_entry;
    exec_pkg::ex_mem_t held;
    exec_pkg::id_ex_t  instr;
    exec_pkg::alu_op_t op;
    exec_pkg::branch_t bt;
    seed = 6;
    next_pc = 32'h0000_1000;
    zero_entry = '0;
    drive_idle();
    nRST = 1'b0;
    repeat (3) next_edge();
    check_entry("reset", zero_entry);
    nRST = 1'b1;
    next_edge();
    check_entry("after reset", zero_entry);

    // Every ALU op with every operand select
    op = op.first();
    repeat (op.num()) begin
      for (int as = 0; as < 2; as++) begin
        for (int bs = 0; bs < 3; bs++) begin
          repeat (2) begin
            instr = random_instr(fresh_pc());
            instr.aluop = op;
            instr.a_sel = as[0];
            instr.b_sel = bs[1:0];
            issue($sformatf("alu %s", op.name()), instr, exec_pkg::FWD_NONE,
                  exec_pkg::FWD_NONE);
          end
        end
      end
      op = op.next();
    end

    for (int f1 = 0; f1 < 3; f1++) begin
      for (int f2 = 0; f2 < 3; f2++) begin
        instr = random_instr(fresh_pc());
        issue($sformatf("forward %0d/%0d", f1, f2), instr, exec_pkg::fwd_sel_t'(f1[1:0]),
              exec_pkg::fwd_sel_t'(f2[1:0]));
      end
    end

    // Signed and unsigned boundaries
    bt = bt.first();
    repeat (bt.num()) begin
      run_branch(bt, 32'd0, 32'd0);
      run_branch(bt, 32'h8000_0000, 32'h7fff_ffff);
      run_branch(bt, 32'h7fff_ffff, 32'h8000_0000);
      run_branch(bt, 32'hffff_ffff, 32'h0000_0001);
      run_branch(bt, 32'h0000_0001, 32'hffff_ffff);
      run_branch(bt, $random(seed), $random(seed));
      bt = bt.next();
    end
    instr = random_instr(fresh_pc());
    instr.branch_instr = 1'b0;
    instr.branch_type = exec_pkg::BR_BEQ;
    instr.rs2_data = instr.rs1_data;
    issue("not a branch", instr, exec_pkg::FWD_NONE, exec_pkg::FWD_NONE);

    for (int js = 0; js < 2; js++) begin
      instr = random_instr(fresh_pc());
      instr.jump_instr = 1'b1;
      instr.j_sel = js[0];
      instr.rs1_data = 32'h8000_0001;
      instr.j_offset = 32'h0000_0124;
      issue($sformatf("jump j_sel %0d", js), instr, exec_pkg::FWD_NONE, exec_pkg::FWD_NONE);
    end

    // All width codes at all offsets
    for (int w = 0; w < 8; w++) begin
      for (int off = 0; off < 4; off++) begin
        instr = random_instr(fresh_pc());
        instr.load_type = exec_pkg::load_t'(w[2:0]);
        instr.a_sel = exec_pkg::A_SEL_DEC;
        instr.b_sel = exec_pkg::B_SEL_DEC;
        instr.op_a = instr.op_a & 32'hffff_fffc;
        instr.op_b = exec_pkg::word_t'(off);
        issue($sformatf("byte_en width %0d offset %0d", w, off), instr,
              exec_pkg::FWD_NONE, exec_pkg::FWD_NONE);
      end
    end

    instr = random_instr(fresh_pc());
    instr.dren = 1'b1;
    instr.dwen = 1'b1;
    issue("control load", instr, exec_pkg::FWD_NONE, exec_pkg::FWD_NONE);
    held = ex_mem;
    pc_en = 1'b0;
    id_ex = random_instr(fresh_pc());
    next_edge();
    check_entry("hold with pc_en low", held);

    dmem_access = 1'b1;
    pc_en = 1'b1;
    next_edge();
    held.dren = 1'b0;
    held.dwen = 1'b0;
    check_entry("request drop", held);

    // Busy data side does not drop the request
    dmem_busy = 1'b1;
    issue("load while busy", random_instr(fresh_pc()), exec_pkg::FWD_NONE, exec_pkg::FWD_NONE);
    dmem_access = 1'b0;
    dmem_busy = 1'b0;

    held = ex_mem;
    pc_en = 1'b0;
    ex_mem_flush = 1'b1;
    next_edge();
    check_entry("flush with pc_en low", held);
    pc_en = 1'b1;
    next_edge();
    check_entry("flush", zero_entry);
    ex_mem_flush = 1'b0;

    issue("before halt", random_instr(fresh_pc()), exec_pkg::FWD_NONE, exec_pkg::FWD_NONE);
    halt = 1'b1;
    pc_en = 1'b0;
    next_edge();
    check_entry("halt", zero_entry);

    drive_idle();
    next_edge();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: sim.f
src/exec_pkg.sv
src/operand_forward.sv
src/int_alu.sv
src/branch_resolve.sv
src/mem_byte_enable.sv
src/ex_mem_latch.sv
src/execute_stage.sv
sim/execute_tb.sv
